/* common/cachePkg.sv */
`default_nettype none

package cachePkg;

	localparam int addrW = 32; // byte address
	localparam int dataW = 32;

	// cpu holds the request until done
	typedef struct packed {
		logic valid;
		logic write;
		logic [addrW-1:0] addr;
		logic [dataW-1:0] wdata;
	} cpuReqT;

	typedef struct packed {
		logic done; // one cycle
		logic [dataW-1:0] rdata;
	} cpuRespT;

	// wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [addrW-1:0] adr;
		logic [dataW-1:0] datW;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [dataW-1:0] datR;
	} wbRespT;

	typedef enum logic [2:0] {
		idle,
		lookup,
		writeBack, // dirty victim out
		refill,
		finish
	} ctrlStateT;

endpackage

`default_nettype wire

/* cache/tagStore.sv */
`timescale 1ns/10ps
`default_nettype none

module tagStore #(
	parameter int numSets = 16,
	parameter int lineWords = 16,
	localparam int idxW = $clog2(numSets),
	localparam int offW = $clog2(lineWords),
	localparam int tagW = cachePkg::addrW - idxW - offW - 2
) (
	input logic clk,
	input logic reset,
	input logic [cachePkg::addrW-1:0] addr,
	output logic hit,
	output logic hitWay,
	output logic victimWay,
	output logic victimDirty,
	output logic [tagW-1:0] victimTag,
	input logic touch,
	input logic setDirty,
	input logic cleanDirty,
	input logic fill,
	input logic way
);
	typedef struct packed {
		logic [tagW-1:0] tag;
		logic [idxW-1:0] idx;
		logic [offW-1:0] off;
		logic [1:0] byteSel;
	} addrFieldsT;

	addrFieldsT a;
	logic [tagW-1:0] tags [2][numSets];
	logic [1:0][numSets-1:0] valid;
	logic [1:0][numSets-1:0] dirty;
	logic [numSets-1:0] lru; // way to evict next
	logic [1:0] wayHit;

	assign a = addr;

	always_comb begin
		for (int w = 0; w < 2; w++)
			wayHit[w] = valid[w][a.idx] && (tags[w][a.idx] == a.tag);
	end

	assign hit = |wayHit;
	assign hitWay = wayHit[1];

	// empty way first, then lru
	always_comb begin
		if (!valid[0][a.idx])
			victimWay = 1'b0;
		else if (!valid[1][a.idx])
			victimWay = 1'b1;
		else
			victimWay = lru[a.idx];
	end

	assign victimDirty = valid[victimWay][a.idx] && dirty[victimWay][a.idx];
	assign victimTag = tags[victimWay][a.idx];

	always_ff @(posedge clk) begin
		if (fill)
			tags[way][a.idx] <= a.tag;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (fill) begin
				valid[way][a.idx] <= 1'b1;
				dirty[way][a.idx] <= 1'b0;
			end
			if (cleanDirty)
				dirty[way][a.idx] <= 1'b0;
			if (setDirty)
				dirty[way][a.idx] <= 1'b1;
			if (touch || fill)
				lru[a.idx] <= ~way; // other way goes stale
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(wayHit[0] && wayHit[1]));

endmodule

`default_nettype wire

/* cache/dataStore.sv */
`timescale 1ns/10ps
`default_nettype none

module dataStore #(
	parameter int numSets = 16,
	parameter int lineWords = 16,
	localparam int idxW = $clog2(numSets),
	localparam int offW = $clog2(lineWords),
	localparam int tagW = cachePkg::addrW - idxW - offW - 2
) (
	input logic clk,
	input logic [cachePkg::addrW-1:0] addr,
	input logic way,
	input logic cpuWrite,
	input logic [cachePkg::dataW-1:0] wdata,
	output logic [cachePkg::dataW-1:0] rdata,
	input logic [offW-1:0] wordIdx,
	input logic lineWe,
	input logic [cachePkg::dataW-1:0] lineWdata,
	output logic [cachePkg::dataW-1:0] lineRdata
);
	import cachePkg::*;

	typedef struct packed {
		logic [tagW-1:0] tag;
		logic [idxW-1:0] idx;
		logic [offW-1:0] off;
		logic [1:0] byteSel;
	} addrFieldsT;

	addrFieldsT a;
	logic [dataW-1:0] mem [2][numSets][lineWords];

	assign a = addr;

	always_ff @(posedge clk) begin
		if (lineWe)
			mem[way][a.idx][wordIdx] <= lineWdata; // refill beat
		else if (cpuWrite)
			mem[way][a.idx][a.off] <= wdata;
	end

	assign rdata = mem[way][a.idx][a.off];
	assign lineRdata = mem[way][a.idx][wordIdx]; // writeback source

endmodule

`default_nettype wire

/* logic/wbLineMaster.sv */
`timescale 1ns/10ps
`default_nettype none

module wbLineMaster #(
	parameter int lineWords = 16,
	localparam int offW = $clog2(lineWords)
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic lineWrite,
	input logic [cachePkg::addrW-1:0] lineAddr,
	output cachePkg::wbReqT wbReq,
	input cachePkg::wbRespT wbResp,
	output logic [offW-1:0] wordIdx,
	output logic lineWe,
	output logic [cachePkg::dataW-1:0] lineWdata,
	input logic [cachePkg::dataW-1:0] lineRdata,
	output logic lineDone
);
	import cachePkg::*;

	logic cycQ;
	logic stbQ;
	logic weQ;
	logic doneQ;
	logic [offW-1:0] beat;
	logic lastBeat;

	assign lastBeat = (beat == offW'(lineWords - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			cycQ <= 1'b0;
			stbQ <= 1'b0;
			weQ <= 1'b0;
			doneQ <= 1'b0;
			beat <= '0;
		end else begin
			doneQ <= 1'b0;
			if (start && !cycQ) begin
				cycQ <= 1'b1;
				stbQ <= 1'b1;
				weQ <= lineWrite;
				beat <= '0;
			end else if (stbQ && wbResp.ack) begin
				stbQ <= 1'b0; // one idle cycle per beat
				if (lastBeat) begin
					cycQ <= 1'b0;
					doneQ <= 1'b1;
				end else
					beat <= beat + 1'b1;
			end else if (cycQ && !stbQ)
				stbQ <= 1'b1;
		end
	end

	assign wbReq.cyc = cycQ;
	assign wbReq.stb = stbQ;
	assign wbReq.we = weQ;
	assign wbReq.adr = {lineAddr[addrW-1:offW+2], beat, 2'b00};
	assign wbReq.datW = lineRdata;

	assign wordIdx = beat;
	assign lineWe = stbQ && wbResp.ack && !weQ; // refill data taken on ack
	assign lineWdata = wbResp.datR;
	assign lineDone = doneQ;

	assert property (@(posedge clk) disable iff (reset) wbReq.stb |-> wbReq.cyc);

	// request held until the slave answers
	assert property (@(posedge clk) disable iff (reset)
		wbReq.stb && !wbResp.ack |=> wbReq.stb && $stable(wbReq.adr) && $stable(wbReq.we));

endmodule

`default_nettype wire

/* cache/cacheControl.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheControl #(
	parameter int numSets = 16,
	parameter int lineWords = 16,
	localparam int idxW = $clog2(numSets),
	localparam int offW = $clog2(lineWords),
	localparam int tagW = cachePkg::addrW - idxW - offW - 2
) (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	input logic hit,
	input logic hitWay,
	input logic victimWay,
	input logic victimDirty,
	input logic [tagW-1:0] victimTag,
	input logic [cachePkg::dataW-1:0] rdata,
	output logic start,
	output logic lineWrite,
	output logic [cachePkg::addrW-1:0] lineAddr,
	output logic lineWay,
	input logic lineDone,
	output logic touch,
	output logic setDirty,
	output logic cleanDirty,
	output logic fill,
	output logic accessWay,
	output logic cpuWrite
);
	import cachePkg::*;

	ctrlStateT state;
	logic wayQ;
	logic startQ;
	logic hitDone;
	logic [addrW-1:0] refillAddr;
	logic [addrW-1:0] wbAddr;

	assign refillAddr = {cpuReq.addr[addrW-1:offW+2], {(offW + 2){1'b0}}};
	assign wbAddr = {victimTag, cpuReq.addr[offW+2 +: idxW], {(offW + 2){1'b0}}};

	assign hitDone = (state == lookup) && hit;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			startQ <= 1'b0;
		end else begin
			startQ <= 1'b0;
			case (state)
				idle: begin
					if (cpuReq.valid)
						state <= lookup;
				end
				lookup: begin
					if (!hit) begin
						startQ <= 1'b1;
						state <= victimDirty ? writeBack : refill;
					end else
						state <= idle;
				end
				writeBack: begin
					if (lineDone) begin
						startQ <= 1'b1; // straight into the refill
						state <= refill;
					end
				end
				refill: begin
					if (lineDone)
						state <= finish;
				end
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// way picked while idle, arrays do not change before lookup
	always_ff @(posedge clk) begin
		if (state == idle && cpuReq.valid)
			wayQ <= hit ? hitWay : victimWay;
		if (state == lookup && !hit)
			lineAddr <= victimDirty ? wbAddr : refillAddr;
		else if (state == writeBack && lineDone)
			lineAddr <= refillAddr;
	end

	assign start = startQ;
	assign lineWrite = (state == writeBack);
	assign lineWay = wayQ;
	assign accessWay = wayQ;

	assign touch = hitDone;
	assign cpuWrite = (hitDone || state == finish) && cpuReq.write;
	assign setDirty = cpuWrite;
	assign cleanDirty = (state == writeBack) && lineDone;
	assign fill = (state == refill) && lineDone; // tag, valid, lru

	assign cpuResp.done = hitDone || (state == finish);
	assign cpuResp.rdata = rdata;

	assert property (@(posedge clk) disable iff (reset)
		cpuResp.done |=> !cpuResp.done);

	assert property (@(posedge clk) disable iff (reset)
		start |-> (state == writeBack || state == refill));

endmodule

`default_nettype wire

/* cache/cacheTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheTop #(
	parameter int numSets = 16,
	parameter int lineWords = 16
) (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	output cachePkg::wbReqT wbReq,
	input cachePkg::wbRespT wbResp
);
	import cachePkg::*;

	localparam int idxW = $clog2(numSets);
	localparam int offW = $clog2(lineWords);
	localparam int tagW = addrW - idxW - offW - 2;

	logic hit;
	logic hitWay;
	logic victimWay;
	logic victimDirty;
	logic [tagW-1:0] victimTag;
	logic [dataW-1:0] rdata;
	logic start;
	logic lineWrite;
	logic [addrW-1:0] lineAddr;
	logic lineWay;
	logic lineDone;
	logic touch;
	logic setDirty;
	logic cleanDirty;
	logic fill;
	logic accessWay;
	logic cpuWrite;
	logic [offW-1:0] wordIdx;
	logic lineWe;
	logic [dataW-1:0] lineWdata;
	logic [dataW-1:0] lineRdata;

	cacheControl #(
		.numSets(numSets),
		.lineWords(lineWords)
	) cacheControl_inst (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.rdata(rdata),
		.start(start),
		.lineWrite(lineWrite),
		.lineAddr(lineAddr),
		.lineWay(lineWay),
		.lineDone(lineDone),
		.touch(touch),
		.setDirty(setDirty),
		.cleanDirty(cleanDirty),
		.fill(fill),
		.accessWay(accessWay),
		.cpuWrite(cpuWrite)
	);

	tagStore #(
		.numSets(numSets),
		.lineWords(lineWords)
	) tagStore_inst (
		.clk(clk),
		.reset(reset),
		.addr(cpuReq.addr),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.touch(touch),
		.setDirty(setDirty),
		.cleanDirty(cleanDirty),
		.fill(fill),
		.way(accessWay)
	);

	dataStore #(
		.numSets(numSets),
		.lineWords(lineWords)
	) dataStore_inst (
		.clk(clk),
		.addr(cpuReq.addr),
		.way(lineWay),
		.cpuWrite(cpuWrite),
		.wdata(cpuReq.wdata),
		.rdata(rdata),
		.wordIdx(wordIdx),
		.lineWe(lineWe),
		.lineWdata(lineWdata),
		.lineRdata(lineRdata)
	);

	wbLineMaster #(
		.lineWords(lineWords)
	) wbLineMaster_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.lineWrite(lineWrite),
		.lineAddr(lineAddr),
		.wbReq(wbReq),
		.wbResp(wbResp),
		.wordIdx(wordIdx),
		.lineWe(lineWe),
		.lineWdata(lineWdata),
		.lineRdata(lineRdata),
		.lineDone(lineDone)
	);

endmodule

`default_nettype wire

/* verif/wbMemModel.sv */
`timescale 1ns/10ps
`default_nettype none

module wbMemModel #(
	parameter int words = 256
) (
	input logic clk,
	input logic reset,
	input cachePkg::wbReqT wbReq,
	output cachePkg::wbRespT wbResp
);
	import cachePkg::*;

	localparam int wordW = $clog2(words);

	logic [dataW-1:0] mem [words];
	logic ackQ;
	logic [dataW-1:0] datQ;
	int unsigned waitLeft; // cycles before the next ack
	logic [wordW-1:0] wordAddr;

	assign wordAddr = wbReq.adr[wordW+1:2];

	always @(posedge clk) begin
		if (reset) begin
			ackQ <= 1'b0;
			datQ <= '0;
			waitLeft <= 0;
			for (int i = 0; i < words; i++)
				mem[i] <= i ^ 32'hA5A5_0000;
		end else if (ackQ)
			ackQ <= 1'b0; // ack lasts one cycle
		else if (wbReq.cyc && wbReq.stb) begin
			if (waitLeft == 0) begin
				ackQ <= 1'b1;
				datQ <= mem[wordAddr];
				if (wbReq.we)
					mem[wordAddr] <= wbReq.datW;
				waitLeft <= $urandom_range(3, 0);
			end else
				waitLeft <= waitLeft - 1;
		end
	end

	assign wbResp.ack = ackQ;
	assign wbResp.datR = datQ;

endmodule

`default_nettype wire

/* verif/cacheTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheTb;
	import cachePkg::*;

	localparam int numSets = 4;
	localparam int lineWords = 8;
	localparam int memWords = 256;
	localparam int numRandom = 1500;
	localparam int directedOps = 13;
	// worst line pair per op, plus reset
	localparam int cycleLimit = (numRandom + directedOps) * (2 * lineWords * 5 + 6) + 16;

	logic clk;
	logic reset;
	cpuReqT cpuReq;
	cpuRespT cpuResp;
	wbReqT wbReq;
	wbRespT wbResp;

	logic [dataW-1:0] refMem [memWords];
	int checks;
	int errors;
	int cycleCount;

	cacheTop #(
		.numSets(numSets),
		.lineWords(lineWords)
	) cacheTop_inst (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.wbReq(wbReq),
		.wbResp(wbResp)
	);

	wbMemModel #(
		.words(memWords)
	) wbMemModel_inst (
		.clk(clk),
		.reset(reset),
		.wbReq(wbReq),
		.wbResp(wbResp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, the cache never finished the access", cycleCount);
		$display("Test failures found");
		$finish;
	end

	function automatic logic [addrW-1:0] byteAddr(input int tag, input int set, input int word);
		return addrW'(((tag * numSets + set) * lineWords + word) * 4);
	endfunction

	function automatic int wordOf(input logic [addrW-1:0] addr);
		return int'(addr >> 2) % memWords;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// holds the request until done, then drops valid
	task automatic cpuAccess(input logic wr, input logic [addrW-1:0] addr,
			input logic [dataW-1:0] wd, output logic [dataW-1:0] rd,
			output int cycles, output logic sawCyc);
		@(posedge clk);
		cpuReq.valid <= 1'b1;
		cpuReq.write <= wr;
		cpuReq.addr <= addr;
		cpuReq.wdata <= wd;
		cycles = 0;
		sawCyc = 1'b0;
		do begin
			@(posedge clk);
			cycles++;
			if (wbReq.cyc)
				sawCyc = 1'b1;
		end while (!cpuResp.done);
		rd = cpuResp.rdata;
		cpuReq.valid <= 1'b0;
		if (wr)
			refMem[wordOf(addr)] = wd;
	endtask

	task automatic readCheck(input string name, input logic [addrW-1:0] addr);
		logic [dataW-1:0] rd;
		int cycles;
		logic sawCyc;
		cpuAccess(1'b0, addr, '0, rd, cycles, sawCyc);
		checkValue(name, refMem[wordOf(addr)], rd);
	endtask

	task automatic writeWord(input logic [addrW-1:0] addr, input logic [dataW-1:0] wd);
		logic [dataW-1:0] rd;
		int cycles;
		logic sawCyc;
		cpuAccess(1'b1, addr, wd, rd, cycles, sawCyc);
	endtask

	initial begin
		logic [addrW-1:0] addr;
		logic [dataW-1:0] wd;
		logic [dataW-1:0] rd;
		int cycles;
		logic sawCyc;

		void'($urandom(32'h91fb));
		checks = 0;
		errors = 0;
		reset = 1'b1;
		cpuReq = '0;
		for (int i = 0; i < memWords; i++)
			refMem[i] = i ^ 32'hA5A5_0000;

		// outputs looked at mid cycle
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i == 4)
				reset <= 1'b0;
			@(negedge clk);
			checkValue("reset quiet done", 0, 32'(cpuResp.done));
			checkValue("reset quiet cyc", 0, 32'(wbReq.cyc));
		end
		repeat (3) begin
			@(negedge clk);
			checkValue("after reset done", 0, 32'(cpuResp.done));
			checkValue("after reset cyc", 0, 32'(wbReq.cyc));
		end

		readCheck("cold read", byteAddr(0, 0, 0));
		readCheck("cold read", byteAddr(7, 3, 7));
		readCheck("cold read", byteAddr(2, 1, 5));
		readCheck("cold read", byteAddr(6, 2, 1));

		addr = byteAddr(1, 1, 3);
		wd = $urandom;
		writeWord(addr, wd);
		cpuAccess(1'b0, addr, '0, rd, cycles, sawCyc);
		checkValue("write then read", wd, rd);
		checkValue("hit latency", 2, cycles);
		checkValue("hit without bus", 0, 32'(sawCyc));
		cpuAccess(1'b0, byteAddr(1, 1, 0), '0, rd, cycles, sawCyc);
		checkValue("same line read", refMem[wordOf(byteAddr(1, 1, 0))], rd);
		checkValue("same line latency", 2, cycles);

		// three tags in set 2, the first one gets written back
		writeWord(byteAddr(3, 2, 4), $urandom);
		writeWord(byteAddr(4, 2, 4), $urandom);
		writeWord(byteAddr(5, 2, 4), $urandom);
		readCheck("eviction first tag", byteAddr(3, 2, 4));
		readCheck("eviction second tag", byteAddr(4, 2, 4));
		readCheck("eviction third tag", byteAddr(5, 2, 4));

		for (int n = 0; n < numRandom; n++) begin
			addr = ($urandom % memWords) * 4;
			if ($urandom_range(1, 0) == 1)
				writeWord(addr, $urandom);
			else
				readCheck("random read", addr);
		end

		repeat (2) @(posedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
common/cachePkg.sv
cache/tagStore.sv
cache/dataStore.sv
logic/wbLineMaster.sv
cache/cacheControl.sv
cache/cacheTop.sv
verif/wbMemModel.sv
verif/cacheTb.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cacheTb -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/VcacheTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
